/* Makefile */
TOP = tb_signdet_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f signdet_core.f -o V$(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

/* common/signdet_host_pkg.sv */
// Host command codes and response byte type
`default_nettype none

package signdet_host_pkg;

  // Only the low three bits of a command byte are decoded
  // so 'i', 'j' and 'k' map onto 1, 2 and 3
  typedef enum logic [2:0] {
    CMD_READ_SCORES = 3'd1,   // 'i' six score bytes
    CMD_REPORT_NOW  = 3'd2,   // 'j' filtered digit
    CMD_REPORT_NEXT = 3'd3    // 'k' raw digit of next frame
  } host_cmd_e;

  // Other codes are accepted and dropped

  // One byte on the response stream
  typedef logic [7:0] resp_byte_t;

  // Digit replies are ASCII, scores go out as raw bytes
  // Scores are sent low byte first

endpackage

`default_nettype wire

/* common/signdet_params.svh */
// Size and constant macros for the sign detection result path
`ifndef SIGNDET_PARAMS_SVH
`define SIGNDET_PARAMS_SVH

// ==============================
// Score stream
// ==============================
`define SIGNDET_SCORE_W 16   // Width of one class score
`define SIGNDET_IDX_W 4      // Class index, up to 16 scores per frame

// ==============================
// Decision filter and LEDs
// ==============================
`define SIGNDET_STABLE_MAX 15  // Stability counter saturates here

// Dimming counter, duty of 1 in 16
`define SIGNDET_PWM_W 4

// ==============================
// Host responses
// ==============================
`define SIGNDET_ASCII_DIGIT 4'h3    // High nibble of ASCII '0'..'9'
`define SIGNDET_READBACK_BYTES 6    // Three scores, two bytes each

`endif

/* common/signdet_result_pkg.sv */
// Score, class index and frame result types
`default_nettype none

`include "signdet_params.svh"

package signdet_result_pkg;

  // One classifier output per class
  typedef logic [`SIGNDET_SCORE_W-1:0] score_t;

  // Index of a class within a frame
  typedef logic [`SIGNDET_IDX_W-1:0] class_idx_t;

  // Published once per frame
  // Winner plus the first three scores for host readback
  typedef struct packed {
    class_idx_t win_idx;   // Highest score, lowest index on a tie
    score_t     score0;
    score_t     score1;
    score_t     score2;
  } frame_result_t;

endpackage

`default_nettype wire

/* host/signdet_host_responder.sv */
// Host command decoder and response byte sequencer
`timescale 1ns/100ps
`default_nettype none

`include "signdet_params.svh"

module signdet_host_responder
  import signdet_result_pkg::*;
  import signdet_host_pkg::*;
(
  input  wire                clk,
  input  wire                resetn,
  input  wire                i_cmd_valid,
  input  wire [7:0]          i_cmd,
  output logic               o_cmd_ready,
  input  wire                i_frame_valid,
  input  wire frame_result_t i_frame_result,
  input  wire class_idx_t    i_cur_idx,
  input  wire class_idx_t    i_det_idx,
  output logic               o_resp_valid,
  output resp_byte_t         o_resp,
  input  wire                i_resp_ready
);

  localparam int CNT_W = $clog2(`SIGNDET_READBACK_BYTES);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SCORES,      // Readback bytes in flight
    ST_NEXT_WAIT,   // Waiting for a frame
    ST_NEXT_PEND,   // cur_idx settles this cycle
    ST_DIGIT        // Single digit in flight
  } state_e;

  state_e                            state_q;
  logic [CNT_W-1:0]                  byte_q;
  logic [8*`SIGNDET_READBACK_BYTES-1:0] snap_q;   // Scores at acceptance

  host_cmd_e        cmd_code;
  logic             cmd_fire;
  logic             resp_fire;
  logic             last_byte;
  logic [CNT_W-1:0] nxt_byte;

  function automatic resp_byte_t to_ascii(input class_idx_t idx);
    return resp_byte_t'({`SIGNDET_ASCII_DIGIT, idx});
  endfunction

  assign cmd_code    = host_cmd_e'(i_cmd[2:0]);
  assign o_cmd_ready = (state_q == ST_IDLE);   // Busy until last byte leaves
  assign cmd_fire    = i_cmd_valid & o_cmd_ready;
  assign resp_fire   = o_resp_valid & i_resp_ready;
  assign last_byte   = (byte_q == CNT_W'(`SIGNDET_READBACK_BYTES - 1));
  assign nxt_byte    = byte_q + 1'b1;

  // ==============================
  // Sequencer
  // ==============================
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      state_q      <= ST_IDLE;
      byte_q       <= '0;
      o_resp_valid <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (cmd_fire)
          begin
            case (cmd_code)
              CMD_READ_SCORES:
              begin
                state_q      <= ST_SCORES;
                byte_q       <= '0;
                o_resp_valid <= 1'b1;
              end
              CMD_REPORT_NOW:
              begin
                state_q      <= ST_DIGIT;
                o_resp_valid <= 1'b1;
              end
              CMD_REPORT_NEXT: state_q <= ST_NEXT_WAIT;
              default:         state_q <= ST_IDLE;  // Unknown code dropped
            endcase
          end
        end
        ST_SCORES:
        begin
          if (resp_fire)
          begin
            if (last_byte)
            begin
              state_q      <= ST_IDLE;
              o_resp_valid <= 1'b0;
            end
            else
              byte_q <= nxt_byte;
          end
        end
        ST_NEXT_WAIT:
        begin
          if (i_frame_valid)
            state_q <= ST_NEXT_PEND;
        end
        ST_NEXT_PEND:
        begin
          state_q      <= ST_DIGIT;
          o_resp_valid <= 1'b1;
        end
        ST_DIGIT:
        begin
          if (resp_fire)
          begin
            state_q      <= ST_IDLE;
            o_resp_valid <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ==============================
  // Response data
  // ==============================
  always_ff @(posedge clk)
  begin
    if ((state_q == ST_IDLE) && cmd_fire)
    begin
      snap_q <= {i_frame_result.score2, i_frame_result.score1, i_frame_result.score0};
      if (cmd_code == CMD_REPORT_NOW)
        o_resp <= to_ascii(i_det_idx);
      else
        o_resp <= i_frame_result.score0[7:0];   // First readback byte
    end
    else if ((state_q == ST_SCORES) && resp_fire && !last_byte)
      o_resp <= snap_q[nxt_byte*8 +: 8];
    else if (state_q == ST_NEXT_PEND)
      o_resp <= to_ascii(i_cur_idx);            // Raw winner of that frame
  end

endmodule

`default_nettype wire

/* result/signdet_frame_scorer.sv */
// Per-frame argmax scorer with capture of the first three class scores
`timescale 1ns/100ps
`default_nettype none

`include "signdet_params.svh"

module signdet_frame_scorer
  import signdet_result_pkg::*;
(
  input  wire           clk,
  input  wire           resetn,
  input  wire           i_score_valid,
  input  wire score_t   i_score,
  input  wire           i_score_last,
  output logic          o_score_ready,
  output logic          o_frame_valid,
  output frame_result_t o_frame_result
);

  class_idx_t beat_q;          // Index of the next beat
  score_t     max_q;
  class_idx_t max_idx_q;
  score_t     cap0_q;
  score_t     cap1_q;
  score_t     cap2_q;
  logic       frame_valid_q;

  score_t     nxt_max;
  class_idx_t nxt_idx;
  score_t     nxt_cap0;
  score_t     nxt_cap1;
  score_t     nxt_cap2;
  logic       beat_fire;
  logic       first_beat;

  // One bubble per frame while the result is published
  assign o_score_ready = ~frame_valid_q;
  assign o_frame_valid = frame_valid_q;
  assign beat_fire     = i_score_valid & o_score_ready;
  assign first_beat    = (beat_q == '0);

  // ==============================
  // Running max and capture
  // ==============================
  always_comb
  begin
    nxt_max  = max_q;
    nxt_idx  = max_idx_q;
    nxt_cap0 = cap0_q;
    nxt_cap1 = cap1_q;
    nxt_cap2 = cap2_q;
    // Strictly greater, so a tie keeps the lower index
    if (first_beat || (i_score > max_q))
    begin
      nxt_max = i_score;
      nxt_idx = beat_q;
    end
    if (first_beat)
    begin
      nxt_cap0 = i_score;
      nxt_cap1 = '0;    // Short frames read back as zero
      nxt_cap2 = '0;
    end
    else if (beat_q == class_idx_t'(1))
      nxt_cap1 = i_score;
    else if (beat_q == class_idx_t'(2))
      nxt_cap2 = i_score;
  end

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      beat_q        <= '0;
      frame_valid_q <= 1'b0;
    end
    else
    begin
      frame_valid_q <= beat_fire & i_score_last;
      if (beat_fire)
        beat_q <= i_score_last ? '0 : beat_q + 1'b1;  // Restart on last beat
    end
  end

  always_ff @(posedge clk)
  begin
    if (beat_fire)
    begin
      max_q     <= nxt_max;
      max_idx_q <= nxt_idx;
      cap0_q    <= nxt_cap0;
      cap1_q    <= nxt_cap1;
      cap2_q    <= nxt_cap2;
    end
  end

  // Result held until the next frame completes
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      o_frame_result <= '0;
    else if (beat_fire && i_score_last)
    begin
      o_frame_result.win_idx <= nxt_idx;
      o_frame_result.score0  <= nxt_cap0;
      o_frame_result.score1  <= nxt_cap1;
      o_frame_result.score2  <= nxt_cap2;
    end
  end

endmodule

`default_nettype wire

/* result/signdet_stability_filter.sv */
// Consecutive-frame decision filter for the winning class index
`timescale 1ns/100ps
`default_nettype none

`include "signdet_params.svh"

module signdet_stability_filter
  import signdet_result_pkg::*;
(
  input  wire             clk,
  input  wire             resetn,
  input  wire             i_frame_valid,
  input  wire class_idx_t i_idx,
  output class_idx_t      o_cur_idx,    // Latest raw winner
  output class_idx_t      o_det_idx     // Filtered decision
);

  localparam int STAB_W = $clog2(`SIGNDET_STABLE_MAX + 1);

  logic [STAB_W-1:0] stable_q;   // Repeats of the current winner

  // ==============================
  // Raw index and repeat count
  // ==============================
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      o_cur_idx <= '0;
      stable_q  <= '0;
    end
    else if (i_frame_valid)
    begin
      o_cur_idx <= i_idx;
      if (i_idx != o_cur_idx)
        stable_q <= '0;            // New class, start over
      else if (stable_q != STAB_W'(`SIGNDET_STABLE_MAX))
        stable_q <= stable_q + 1'b1;
    end
  end

  // ==============================
  // Decision update
  // ==============================
  // Count of 2 means three equal frames in a row
  // Window of 2 or 3 gives the update a second chance
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      o_det_idx <= '0;
    else if ((stable_q == STAB_W'(2)) || (stable_q == STAB_W'(3)))
      o_det_idx <= o_cur_idx;
  end

endmodule

`default_nettype wire

/* signdet_core.f */
+incdir+common
common/signdet_result_pkg.sv
common/signdet_host_pkg.sv
result/signdet_frame_scorer.sv
result/signdet_stability_filter.sv
host/signdet_host_responder.sv
source/signdet_status_led.sv
source/signdet_core_top.sv
tests/signdet_core_asserts.sv
tests/tb_signdet_core.sv

/* source/signdet_core_top.sv */
// Top level of the sign detection result path with its four blocks
`timescale 1ns/100ps
`default_nettype none

module signdet_core_top
  import signdet_result_pkg::*;
  import signdet_host_pkg::*;
(
  input  wire             clk,
  input  wire             resetn,

  // Classifier score stream
  input  wire             i_score_valid,
  input  wire score_t     i_score,
  input  wire             i_score_last,
  output wire             o_score_ready,

  // Host commands and responses
  input  wire             i_cmd_valid,
  input  wire [7:0]       i_cmd,
  output wire             o_cmd_ready,
  output wire             o_resp_valid,
  output wire resp_byte_t o_resp,
  input  wire             i_resp_ready,

  // Status LEDs
  output wire class_idx_t o_led,
  output wire [2:0]       o_rgb
);

  logic          frame_valid;    // One pulse per frame
  frame_result_t frame_result;
  class_idx_t    cur_idx;
  class_idx_t    det_idx;

  // ==============================
  // Result path
  // ==============================
  signdet_frame_scorer signdet_frame_scorer_inst (
    .clk            (clk),
    .resetn         (resetn),
    .i_score_valid  (i_score_valid),
    .i_score        (i_score),
    .i_score_last   (i_score_last),
    .o_score_ready  (o_score_ready),
    .o_frame_valid  (frame_valid),
    .o_frame_result (frame_result)
  );

  signdet_stability_filter signdet_stability_filter_inst (
    .clk           (clk),
    .resetn        (resetn),
    .i_frame_valid (frame_valid),
    .i_idx         (frame_result.win_idx),
    .o_cur_idx     (cur_idx),
    .o_det_idx     (det_idx)
  );

  // ==============================
  // Host and LEDs
  // ==============================
  signdet_host_responder signdet_host_responder_inst (
    .clk            (clk),
    .resetn         (resetn),
    .i_cmd_valid    (i_cmd_valid),
    .i_cmd          (i_cmd),
    .o_cmd_ready    (o_cmd_ready),
    .i_frame_valid  (frame_valid),
    .i_frame_result (frame_result),
    .i_cur_idx      (cur_idx),
    .i_det_idx      (det_idx),
    .o_resp_valid   (o_resp_valid),
    .o_resp         (o_resp),
    .i_resp_ready   (i_resp_ready)
  );

  signdet_status_led signdet_status_led_inst (
    .clk       (clk),
    .resetn    (resetn),
    .i_det_idx (det_idx),
    .o_led     (o_led),
    .o_rgb     (o_rgb)
  );

endmodule

`default_nettype wire

/* source/signdet_status_led.sv */
// Status LED driver with index code and dimmed colour outputs
`timescale 1ns/100ps
`default_nettype none

`include "signdet_params.svh"

module signdet_status_led
  import signdet_result_pkg::*;
(
  input  wire             clk,
  input  wire             resetn,
  input  wire class_idx_t i_det_idx,
  output class_idx_t      o_led,
  output logic [2:0]      o_rgb     // Green, blue, red from bit 0 up
);

  logic [`SIGNDET_PWM_W-1:0] pwm_q;   // Free-running dimmer
  logic                      pwm_on;

  assign pwm_on = (pwm_q == '0);

  // ==============================
  // LED registers
  // ==============================
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      pwm_q <= '0;
      o_led <= '0;
      o_rgb <= '0;
    end
    else
    begin
      pwm_q <= pwm_q + 1'b1;
      o_led <= i_det_idx;
      // One cycle in sixteen keeps the colour LEDs dim
      o_rgb <= {i_det_idx[3], i_det_idx[2], i_det_idx[1]} & {3{pwm_on}};
    end
  end

endmodule

`default_nettype wire

/* tests/signdet_core_asserts.sv */
// Concurrent assertions on the handshakes and control outputs of the core top level
`timescale 1ns/100ps
`default_nettype none

module signdet_core_asserts (
  input wire       clk,
  input wire       resetn,
  input wire       o_resp_valid,
  input wire [7:0] o_resp,
  input wire       i_resp_ready,
  input wire       o_cmd_ready,
  input wire       o_score_ready,
  input wire [3:0] o_led,
  input wire [2:0] o_rgb
);

  int assert_failures = 0;   // Summed into the testbench error count

  // ==============================
  // Response stream
  // ==============================
  // Stalled byte stays put
  resp_held: assert property (
    @(posedge clk) disable iff (!resetn)
    (o_resp_valid && !i_resp_ready) |=> (o_resp_valid && $stable(o_resp)))
  else
  begin
    $error("o_resp changed or dropped while the host stalled it");
    assert_failures++;
  end

  // No new command while a byte is pending
  busy_while_resp: assert property (
    @(posedge clk) disable iff (!resetn)
    o_resp_valid |-> !o_cmd_ready)
  else
  begin
    $error("o_cmd_ready high while a response byte is pending");
    assert_failures++;
  end

  // ==============================
  // Control outputs
  // ==============================
  no_unknown: assert property (
    @(posedge clk) disable iff (!resetn)
    !$isunknown({o_resp_valid, o_cmd_ready, o_score_ready, o_led, o_rgb}))
  else
  begin
    $error("control output unknown after reset");
    assert_failures++;
  end

endmodule

`default_nettype wire

/* tests/signdet_input.txt */
// Ops as hex words: 1 frame (count, scores), 2 o_led, 3 report-now digit,
// 4 readback (score0 score1 score2), 5 report-next (digit, count, scores), 6 bad cmd, 7 rgb, 0 end
// Argmax with a distinct maximum, then a tie, each read back
1 4 1111 a222 0333 0044
4 1111 a222 0333
1 5 0100 0050 c300 c300 0020
4 0100 0050 c300
// Two more tied frames, class 2 decided on the third
1 5 0100 0050 c300 c300 0020
2 0
1 5 0100 0050 c300 c300 0020
2 2
3 32
// Stability A,A,B,A,A,A with A = 5 and B = 7
1 8 0001 0002 0003 0004 0005 0100 0006 0007
2 2
1 8 0001 0002 0003 0004 0005 0100 0006 0007
2 2
1 8 0001 0002 0003 0004 0005 0100 0006 0200
2 2
1 8 0001 0002 0003 0004 0005 0100 0006 0007
2 2
1 8 0001 0002 0003 0004 0005 0100 0006 0007
2 2
1 8 0001 0002 0003 0004 0005 0100 0006 0007
2 5
3 35
7
// Report next sees raw winner 9, report now keeps 5
5 39 a 12a0 34b1 56c2 0001 0002 0003 0004 0005 0006 7fff
3 35
4 12a0 34b1 56c2
// Codes with low bits 0 and 4
6 68
6 6c
// Class 10 three times for the colour LEDs
1 b 0000 0001 0002 0003 0004 0005 0006 0007 0008 0009 f000
2 5
1 b 0000 0001 0002 0003 0004 0005 0006 0007 0008 0009 f000
2 5
1 b 0000 0001 0002 0003 0004 0005 0006 0007 0008 0009 f000
2 a
7
3 3a
0

/* tests/tb_signdet_core.sv */
// Testbench for the sign detection core with file stimulus, reference model and checks
`timescale 1ns/100ps
`default_nettype none

`include "signdet_params.svh"

module tb_signdet_core;

  localparam int CLK_HALF  = 2;
  localparam int MEM_DEPTH = 512;
  localparam int TIMEOUT   = 200;   // Cycles allowed per wait
  localparam int SETTLE    = 6;     // Last beat to o_led, with margin
  localparam int QUIET     = 40;

  logic        clk;
  logic        resetn;
  logic        i_score_valid;
  logic [15:0] i_score;
  logic        i_score_last;
  wire         o_score_ready;
  logic        i_cmd_valid;
  logic [7:0]  i_cmd;
  wire         o_cmd_ready;
  wire         o_resp_valid;
  wire  [7:0]  o_resp;
  logic        i_resp_ready;
  wire  [3:0]  o_led;
  wire  [2:0]  o_rgb;

  logic [15:0] stim_mem [0:MEM_DEPTH-1];
  logic [15:0] op_word;
  string       op_name;
  integer      seed;
  int          pc;
  int          errors;
  int          op_errors;
  int          tests;
  int          failed_tests;
  bit          abort;
  bit          finished;

  // Reference model of scorer and filter
  logic [3:0]  ref_cur;
  logic [3:0]  ref_stable;
  logic [3:0]  ref_det;
  logic [15:0] ref_score [0:2];

  signdet_core_top signdet_core_top_inst (
    .clk           (clk),
    .resetn        (resetn),
    .i_score_valid (i_score_valid),
    .i_score       (i_score),
    .i_score_last  (i_score_last),
    .o_score_ready (o_score_ready),
    .i_cmd_valid   (i_cmd_valid),
    .i_cmd         (i_cmd),
    .o_cmd_ready   (o_cmd_ready),
    .o_resp_valid  (o_resp_valid),
    .o_resp        (o_resp),
    .i_resp_ready  (i_resp_ready),
    .o_led         (o_led),
    .o_rgb         (o_rgb)
  );

  bind signdet_core_top signdet_core_asserts signdet_core_asserts_inst (
    .clk           (clk),
    .resetn        (resetn),
    .o_resp_valid  (o_resp_valid),
    .o_resp        (o_resp),
    .i_resp_ready  (i_resp_ready),
    .o_cmd_ready   (o_cmd_ready),
    .o_score_ready (o_score_ready),
    .o_led         (o_led),
    .o_rgb         (o_rgb)
  );

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ==============================
  // Reporting and timing helpers
  // ==============================
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    op_errors++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0d ns: %s", $time, what);
    op_errors++;
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // ==============================
  // Stream drivers
  // ==============================
  task automatic send_beat(input logic [15:0] score, input logic last);
    int waited;
    bit done;
    waited        = 0;
    done          = 1'b0;
    i_score_valid = 1'b1;
    i_score       = score;
    i_score_last  = last;
    while (!done && waited < TIMEOUT)
    begin
      @(negedge clk);
      done = o_score_ready;     // Transfers on the coming edge
      @(posedge clk);
      #1;
      waited++;
    end
    i_score_valid = 1'b0;
    i_score_last  = 1'b0;
    if (!done)
    begin
      report_problem("score beat was never accepted");
      abort = 1'b1;
    end
  endtask

  task automatic send_cmd(input logic [7:0] code);
    int waited;
    bit done;
    waited      = 0;
    done        = 1'b0;
    i_cmd_valid = 1'b1;
    i_cmd       = code;
    while (!done && waited < TIMEOUT)
    begin
      @(negedge clk);
      done = o_cmd_ready;
      @(posedge clk);
      #1;
      waited++;
    end
    i_cmd_valid = 1'b0;
    if (!done)
    begin
      report_problem($sformatf("command %h was never accepted", code));
      abort = 1'b1;
    end
  endtask

  // Busy must hold until the byte is taken
  task automatic recv_byte(input bit stall, output logic [7:0] data);
    int waited;
    bit done;
    waited = 0;
    done   = 1'b0;
    data   = 8'h00;
    while (!done && waited < TIMEOUT)
    begin
      i_resp_ready = stall ? ($random(seed) % 3 != 0) : 1'b1;
      @(negedge clk);
      if (o_cmd_ready !== 1'b0)
        report_mismatch("o_cmd_ready while busy", o_cmd_ready, 0);
      if (o_resp_valid && i_resp_ready)
      begin
        done = 1'b1;
        data = o_resp;
      end
      @(posedge clk);
      #1;
      waited++;
    end
    i_resp_ready = 1'b0;
    if (!done)
    begin
      report_problem("no response byte arrived");
      abort = 1'b1;
    end
  endtask

  task automatic check_idle_after();
    @(negedge clk);
    if (o_cmd_ready !== 1'b1)
      report_mismatch("o_cmd_ready after response", o_cmd_ready, 1);
    if (o_resp_valid !== 1'b0)
      report_mismatch("o_resp_valid after response", o_resp_valid, 0);
    @(posedge clk);
    #1;
  endtask

  // ==============================
  // Ops from the input file
  // ==============================
  task automatic send_frame();
    int          n;
    int          k;
    logic [15:0] s;
    logic [15:0] best;
    logic [3:0]  win;
    n    = int'(stim_mem[pc]);
    pc++;
    best = '0;
    win  = '0;
    for (k = 0; k < 3; k++)
      ref_score[k] = '0;        // Short frames read back as zero
    for (k = 0; k < n && !abort; k++)
    begin
      s = stim_mem[pc + k];
      if (k == 0 || s > best)   // Tie keeps the lower index
      begin
        best = s;
        win  = 4'(k);
      end
      if (k < 3)
        ref_score[k] = s;
      if ($random(seed) % 4 == 0)
        idle_cycles(1);
      send_beat(s, k == n - 1);
    end
    pc += n;
    if (win != ref_cur)
      ref_stable = '0;
    else if (ref_stable != 4'd15)
      ref_stable = ref_stable + 1'b1;
    ref_cur = win;
    if (ref_stable == 4'd2 || ref_stable == 4'd3)
      ref_det = ref_cur;
    if (!abort)
    begin
      @(negedge clk);
      if (o_score_ready !== 1'b0)
        report_mismatch("o_score_ready in frame bubble", o_score_ready, 0);
      @(negedge clk);
      if (o_score_ready !== 1'b1)
        report_mismatch("o_score_ready after bubble", o_score_ready, 1);
      @(posedge clk);
      #1;
      idle_cycles(SETTLE);
    end
  endtask

  task automatic check_led();
    logic [3:0] file_idx;
    file_idx = stim_mem[pc][3:0];
    pc++;
    if (file_idx !== ref_det)
      report_problem("o_led value in input file disagrees with the filter rule");
    @(negedge clk);
    if (o_led !== ref_det)
      report_mismatch("o_led", o_led, ref_det);
    @(posedge clk);
    #1;
  endtask

  task automatic report_now();
    logic [7:0] file_byte;
    logic [7:0] got;
    logic [7:0] exp;
    file_byte = stim_mem[pc][7:0];
    pc++;
    exp = 8'h30 + 8'(ref_det);
    if (file_byte !== exp)
      report_problem("report-now digit in input file disagrees with the model");
    send_cmd(8'h6a);   // 'j'
    if (!abort)
      recv_byte(1'b0, got);
    if (!abort)
    begin
      if (got !== exp)
        report_mismatch("o_resp digit", got, exp);
      check_idle_after();
    end
  endtask

  task automatic read_scores();
    logic [7:0] got;
    logic [7:0] exp;
    int         k;
    for (k = 0; k < 3; k++)
      if (stim_mem[pc + k] !== ref_score[k])
        report_problem("readback score in input file disagrees with the model");
    pc += 3;
    send_cmd(8'h69);   // 'i'
    for (k = 0; k < 6 && !abort; k++)
    begin
      recv_byte(1'b1, got);
      exp = (k % 2 == 0) ? ref_score[k / 2][7:0] : ref_score[k / 2][15:8];
      if (!abort && got !== exp)
        report_mismatch($sformatf("o_resp byte %0d", k), got, exp);
    end
    if (!abort)
      check_idle_after();
  endtask

  task automatic report_next();
    logic [7:0] file_byte;
    logic [7:0] got;
    logic [7:0] exp;
    file_byte = stim_mem[pc][7:0];
    pc++;
    send_cmd(8'h6b);   // 'k'
    if (!abort)
    begin
      @(negedge clk);
      if (o_cmd_ready !== 1'b0)
        report_mismatch("o_cmd_ready while waiting for a frame", o_cmd_ready, 0);
      @(posedge clk);
      #1;
      send_frame();
    end
    exp = 8'h30 + 8'(ref_cur);   // Raw winner of that frame
    if (file_byte !== exp)
      report_problem("report-next digit in input file disagrees with the model");
    if (!abort)
      recv_byte(1'b0, got);
    if (!abort)
    begin
      if (got !== exp)
        report_mismatch("o_resp digit", got, exp);
      check_idle_after();
    end
  endtask

  task automatic ignore_cmd();
    logic [7:0] code;
    bit         seen;
    code = stim_mem[pc][7:0];
    pc++;
    seen = 1'b0;
    send_cmd(code);
    repeat (QUIET)
    begin
      @(negedge clk);
      if (o_resp_valid)
        seen = 1'b1;
      @(posedge clk);
      #1;
    end
    if (seen)
      report_problem($sformatf("unknown command %h produced a response", code));
    @(negedge clk);
    if (o_cmd_ready !== 1'b1)
      report_mismatch("o_cmd_ready after unknown command", o_cmd_ready, 1);
    @(posedge clk);
    #1;
  endtask

  // Two dim pulses per bit in 32 cycles
  task automatic check_rgb();
    int cnt [0:2];
    int j;
    for (j = 0; j < 3; j++)
      cnt[j] = 0;
    repeat (32)
    begin
      @(negedge clk);
      for (j = 0; j < 3; j++)
        if (o_rgb[j])
          cnt[j]++;
      @(posedge clk);
      #1;
    end
    for (j = 0; j < 3; j++)
      if (cnt[j] != (ref_det[j + 1] ? 2 : 0))
        report_mismatch($sformatf("o_rgb[%0d] high count", j), cnt[j],
                        ref_det[j + 1] ? 2 : 0);
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial
  begin
    seed          = 32'he10900aa;
    resetn        = 1'b0;
    i_score_valid = 1'b0;
    i_score       = '0;
    i_score_last  = 1'b0;
    i_cmd_valid   = 1'b0;
    i_cmd         = '0;
    i_resp_ready  = 1'b0;
    errors        = 0;
    tests         = 0;
    failed_tests  = 0;
    abort         = 1'b0;
    finished      = 1'b0;
    ref_cur       = '0;
    ref_stable    = '0;
    ref_det       = '0;
    $readmemh("tests/signdet_input.txt", stim_mem);
    repeat (2) @(posedge clk);
    #1;
    resetn = 1'b1;
    pc     = 0;
    while (!finished && !abort && pc < MEM_DEPTH)
    begin
      op_word   = stim_mem[pc];
      pc++;
      op_errors = 0;
      case (op_word)
        16'h0: finished = 1'b1;
        16'h1:
        begin
          op_name = "frame";
          send_frame();
        end
        16'h2:
        begin
          op_name = "led";
          check_led();
        end
        16'h3:
        begin
          op_name = "report now";
          report_now();
        end
        16'h4:
        begin
          op_name = "score readback";
          read_scores();
        end
        16'h5:
        begin
          op_name = "report next";
          report_next();
        end
        16'h6:
        begin
          op_name = "unknown command";
          ignore_cmd();
        end
        16'h7:
        begin
          op_name = "colour leds";
          check_rgb();
        end
        default:
        begin
          op_name = "bad op";
          report_problem($sformatf("unknown op %h in input file", op_word));
          abort = 1'b1;
        end
      endcase
      if (!finished)
      begin
        tests++;
        if (op_errors != 0)
          failed_tests++;
        errors += op_errors;
        $display("op %0d %s: %s", tests, op_name, (op_errors == 0) ? "pass" : "fail");
      end
    end
    if (!finished && !abort)
    begin
      $display("ERROR: input file has no end marker");
      errors++;
    end
    if (signdet_core_top_inst.signdet_core_asserts_inst.assert_failures != 0)
    begin
      $display("ERROR: bound assertions failed %0d time(s)",
               signdet_core_top_inst.signdet_core_asserts_inst.assert_failures);
      errors += signdet_core_top_inst.signdet_core_asserts_inst.assert_failures;
    end
    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0 && !abort)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
